/* bench/clockGen.sv */
module clockGen
(
	output logic clk,
	output logic reset
);

	// Reset spans eight rising edges, released just after the last
	initial
	begin
		clk = 1'b0;
		reset = 1'b1;
		repeat (8) @(posedge clk);
		#1 reset = 1'b0;
	end

	// Period of 4
	always #2 clk = ~clk;

endmodule

/* bench/mipsCore_assertions.sv */
module mipsCore_assertions
(
	input logic clk,
	input logic reset,
	input logic cyc,
	input logic stb,
	input mipsPkg::word_t adr,
	input logic ack
);

	////////////////////////////////////////////////////////////
	// Wishbone classic master rules
	////////////////////////////////////////////////////////////

	// Strobe only inside a cycle
	stbInCyc: assert property (@(posedge clk) disable iff (reset) stb |-> cyc)
		else $error("stb high without cyc");

	// Request and address held until ack
	adrHeld: assert property (@(posedge clk) disable iff (reset)
		(stb && !ack) |=> (stb && $stable(adr)))
		else $error("request or address changed before ack");

	// Bus quiet while reset is applied
	quietInReset: assert property (@(posedge clk) reset |=> !stb)
		else $error("stb high during reset");

endmodule

/* bench/mipsCore_tb.sv */
module mipsCore_tb;
	import mipsPkg::*;

	localparam int executedCount = 52;
	localparam int maxDelay = 3;
	localparam int cycleLimit = executedCount * 2 * (maxDelay + 3) + 20;

	logic clk;
	logic reset;
	logic instrCyc;
	logic instrStb;
	word_t instrAdr;
	word_t instrDat;
	logic instrAck;
	logic dataCyc;
	logic dataStb;
	logic dataWe;
	word_t dataAdr;
	word_t dataWrite;
	word_t dataRead;
	logic dataAck;

	// Bus side memories
	word_t imem [64];
	word_t dmem [64];
	int progLen;

	// Reference model state
	word_t modelRegs [32];
	word_t modelMem [64];
	word_t modelPc;
	word_t storeAddrQ [$];
	word_t storeDataQ [$];

	// Ack delay state
	logic [15:0] lfsrState;
	logic [1:0] instrDelay;
	logic [1:0] dataDelay;
	logic instrWaiting;
	logic dataWaiting;
	int stallCycles;

	// Per test bookkeeping
	word_t testStart [5];
	string testName [5];
	int testChecks [5];
	int testErrors [5];
	int curTest;
	int checkCount;
	int errorCount;
	int fetchCount;
	int storeCount;
	int cycleCount;
	logic runDone;

	clockGen clocks
	(
		.clk(clk),
		.reset(reset)
	);

	mipsCore u_dut
	(
		.clk(clk),
		.reset(reset),
		.instrCyc(instrCyc),
		.instrStb(instrStb),
		.instrAdr(instrAdr),
		.instrDat(instrDat),
		.instrAck(instrAck),
		.dataCyc(dataCyc),
		.dataStb(dataStb),
		.dataWe(dataWe),
		.dataAdr(dataAdr),
		.dataWrite(dataWrite),
		.dataRead(dataRead),
		.dataAck(dataAck)
	);

	bind fetchUnit mipsCore_assertions instrBusChecks
	(
		.clk(clk),
		.reset(reset),
		.cyc(instrCyc),
		.stb(instrStb),
		.adr(instrAdr),
		.ack(instrAck)
	);

	bind memoryAccess mipsCore_assertions dataBusChecks
	(
		.clk(clk),
		.reset(reset),
		.cyc(dataCyc),
		.stb(dataStb),
		.adr(dataAdr),
		.ack(dataAck)
	);

	////////////////////////////////////////////////////////////
	// Instruction encoding and memory fill
	////////////////////////////////////////////////////////////

	function automatic word_t rInstr(input regAddr_t rs, input regAddr_t rt,
		input regAddr_t rd, input logic [5:0] fn);
		rInstr = {opRType, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic word_t iInstr(input opcode_t op, input regAddr_t rs,
		input regAddr_t rt, input logic [15:0] imm);
		iInstr = {op, rs, rt, imm};
	endfunction

	// Target is a word address
	function automatic word_t jInstr(input logic [25:0] target);
		jInstr = {opJ, target};
	endfunction

	// Every address bit shows up in the word
	function automatic word_t fillWord(input int idx);
		fillWord = ((word_t'(idx) + 32'd1) * 32'h9E37_79B9) ^ 32'h0000_5A5A;
	endfunction

	task emit(input word_t w);
		imem[progLen[5:0]] = w;
		progLen = progLen + 1;
	endtask

	task loadProgram();
		progLen = 0;
		// R-type, words 0 to 13
		emit(iInstr(opAddi, 5'd0, 5'd1, 16'd7));
		emit(iInstr(opAddi, 5'd0, 5'd2, 16'hFFFD));
		emit(rInstr(5'd1, 5'd2, 5'd3, fnAdd));
		emit(rInstr(5'd2, 5'd1, 5'd4, fnSub));
		emit(rInstr(5'd1, 5'd2, 5'd5, fnAnd));
		emit(rInstr(5'd1, 5'd2, 5'd6, fnOr));
		emit(rInstr(5'd2, 5'd1, 5'd7, fnSlt));
		emit(rInstr(5'd1, 5'd2, 5'd8, fnSlt));
		emit(iInstr(opSw, 5'd0, 5'd3, 16'd0));
		emit(iInstr(opSw, 5'd0, 5'd4, 16'd4));
		emit(iInstr(opSw, 5'd0, 5'd5, 16'd8));
		emit(iInstr(opSw, 5'd0, 5'd6, 16'd12));
		emit(iInstr(opSw, 5'd0, 5'd7, 16'd16));
		emit(iInstr(opSw, 5'd0, 5'd8, 16'd20));
		// Immediates, words 14 to 25, sign versus zero extension
		emit(iInstr(opAddi, 5'd1, 5'd9, 16'hFFF8));
		emit(iInstr(opSlti, 5'd2, 5'd10, 16'hFFFE));
		emit(iInstr(opSlti, 5'd1, 5'd11, 16'hFFFF));
		emit(iInstr(opAndi, 5'd6, 5'd12, 16'h8001));
		emit(iInstr(opOri, 5'd0, 5'd13, 16'h8000));
		emit(iInstr(opAddi, 5'd0, 5'd14, 16'h8000));
		emit(iInstr(opSw, 5'd0, 5'd9, 16'd24));
		emit(iInstr(opSw, 5'd0, 5'd10, 16'd28));
		emit(iInstr(opSw, 5'd0, 5'd11, 16'd32));
		emit(iInstr(opSw, 5'd0, 5'd12, 16'd36));
		emit(iInstr(opSw, 5'd0, 5'd13, 16'd40));
		emit(iInstr(opSw, 5'd0, 5'd14, 16'd44));
		// Loads and r0 writes, words 26 to 33
		emit(iInstr(opLw, 5'd0, 5'd15, 16'd128));
		emit(iInstr(opLw, 5'd0, 5'd16, 16'd132));
		emit(iInstr(opSw, 5'd0, 5'd15, 16'd192));
		emit(iInstr(opSw, 5'd0, 5'd16, 16'd196));
		emit(iInstr(opLw, 5'd0, 5'd0, 16'd128));
		emit(iInstr(opSw, 5'd0, 5'd0, 16'd200));
		emit(rInstr(5'd1, 5'd1, 5'd0, fnAdd));
		emit(iInstr(opSw, 5'd0, 5'd0, 16'd204));
		// Branches, words 34 to 43, loop of three at 36
		emit(iInstr(opAddi, 5'd0, 5'd17, 16'd3));
		emit(iInstr(opAddi, 5'd0, 5'd18, 16'd0));
		emit(iInstr(opAddi, 5'd18, 5'd18, 16'd5));
		emit(iInstr(opAddi, 5'd17, 5'd17, 16'hFFFF));
		emit(iInstr(opBne, 5'd17, 5'd0, 16'hFFFD));
		emit(iInstr(opBeq, 5'd17, 5'd0, 16'd1));
		emit(iInstr(opAddi, 5'd0, 5'd18, 16'd99));
		emit(iInstr(opBeq, 5'd18, 5'd0, 16'd1));
		emit(iInstr(opBne, 5'd18, 5'd18, 16'd1));
		emit(iInstr(opSw, 5'd0, 5'd18, 16'd208));
		// Jumps, words 44 to 48, ends on a jump to itself
		emit(jInstr(26'd47));
		emit(iInstr(opAddi, 5'd0, 5'd18, 16'd77));
		emit(iInstr(opSw, 5'd0, 5'd18, 16'd212));
		emit(iInstr(opSw, 5'd0, 5'd1, 16'd216));
		emit(jInstr(26'd48));
	endtask

	////////////////////////////////////////////////////////////
	// Random ack delays
	////////////////////////////////////////////////////////////

	function logic [15:0] lfsrNext(input logic [15:0] s);
		lfsrNext = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	// One step per delay bit
	function logic [1:0] pickDelay();
		logic [1:0] d;
		d = 2'd0;
		for (int i = 0; i < 2; i++)
		begin
			lfsrState = lfsrNext(lfsrState);
			d = {d[0], lfsrState[0]};
		end
		pickDelay = d;
	endfunction

	////////////////////////////////////////////////////////////
	// Reference instruction model
	////////////////////////////////////////////////////////////

	function void writeModelReg(input regAddr_t r, input word_t v);
		if (r != 5'd0)
			modelRegs[r] = v;
	endfunction

	function void stepModel(input word_t instr);
		regAddr_t rs;
		regAddr_t rt;
		regAddr_t rd;
		word_t a;
		word_t b;
		word_t seImm;
		word_t zeImm;
		word_t addr;
		word_t nextPc;
		rs = instr[25:21];
		rt = instr[20:16];
		rd = instr[15:11];
		a = modelRegs[rs];
		b = modelRegs[rt];
		seImm = {{16{instr[15]}}, instr[15:0]};
		zeImm = {16'h0000, instr[15:0]};
		addr = a + seImm;
		nextPc = modelPc + 32'd4;
		case (instr[31:26])
			opRType:
				case (instr[5:0])
					fnAdd: writeModelReg(rd, a + b);
					fnSub: writeModelReg(rd, a - b);
					fnAnd: writeModelReg(rd, a & b);
					fnOr: writeModelReg(rd, a | b);
					fnSlt: writeModelReg(rd, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
					default: ;
				endcase
			opAddi: writeModelReg(rt, a + seImm);
			opSlti: writeModelReg(rt, ($signed(a) < $signed(seImm)) ? 32'd1 : 32'd0);
			// Logical immediates zero-extended
			opAndi: writeModelReg(rt, a & zeImm);
			opOri: writeModelReg(rt, a | zeImm);
			opLw: writeModelReg(rt, modelMem[addr[7:2]]);
			opSw:
			begin
				modelMem[addr[7:2]] = b;
				storeAddrQ.push_back(addr);
				storeDataQ.push_back(b);
			end
			opBeq:
			begin
				if (a == b)
					nextPc = nextPc + {seImm[29:0], 2'b00};
			end
			opBne:
			begin
				if (a != b)
					nextPc = nextPc + {seImm[29:0], 2'b00};
			end
			opJ: nextPc = {nextPc[31:28], instr[25:0], 2'b00};
			default: ;
		endcase
		modelPc = nextPc;
	endfunction

	// Test group of a fetch address
	function int testOf(input word_t addr);
		int idx;
		idx = 0;
		for (int i = 1; i < 5; i++)
		begin
			if (addr >= testStart[i])
				idx = i;
		end
		testOf = idx;
	endfunction

	task reportTest(input int t);
		$display("test %0d %s: %0d checks, %0d errors", t + 1, testName[t],
			testChecks[t], testErrors[t]);
	endtask

	task countError();
		errorCount = errorCount + 1;
		testErrors[curTest] = testErrors[curTest] + 1;
	endtask

	task countCheck();
		checkCount = checkCount + 1;
		testChecks[curTest] = testChecks[curTest] + 1;
	endtask

	////////////////////////////////////////////////////////////
	// Wishbone slaves, driven 1 after the edge
	////////////////////////////////////////////////////////////

	always @(posedge clk)
	begin
		#1;
		if (reset)
		begin
			instrAck = 1'b0;
			instrWaiting = 1'b0;
		end
		// Handshake seen at this edge
		else if (instrAck)
			instrAck = 1'b0;
		else if (instrStb)
		begin
			if (!instrWaiting)
			begin
				instrWaiting = 1'b1;
				instrDelay = pickDelay();
				stallCycles = stallCycles + int'(instrDelay);
			end
			if (instrDelay == 2'd0)
			begin
				instrDat = imem[instrAdr[7:2]];
				instrAck = 1'b1;
				instrWaiting = 1'b0;
			end
			else
				instrDelay = instrDelay - 2'd1;
		end
	end

	always @(posedge clk)
	begin
		#1;
		if (reset)
		begin
			dataAck = 1'b0;
			dataWaiting = 1'b0;
		end
		else if (dataAck)
			dataAck = 1'b0;
		else if (dataStb)
		begin
			if (!dataWaiting)
			begin
				dataWaiting = 1'b1;
				dataDelay = pickDelay();
				stallCycles = stallCycles + int'(dataDelay);
			end
			if (dataDelay == 2'd0)
			begin
				if (dataWe)
					dmem[dataAdr[7:2]] = dataWrite;
				else
					dataRead = dmem[dataAdr[7:2]];
				dataAck = 1'b1;
				dataWaiting = 1'b0;
			end
			else
				dataDelay = dataDelay - 2'd1;
		end
	end

	////////////////////////////////////////////////////////////
	// Compare against the model, mid cycle
	////////////////////////////////////////////////////////////

	always @(negedge clk)
	begin
		int idx;
		word_t prevPc;
		word_t expAddr;
		word_t expData;
		if (!reset && !runDone && instrStb && instrAck)
		begin
			idx = testOf(instrAdr);
			if (idx > curTest)
			begin
				reportTest(curTest);
				curTest = idx;
			end
			fetchCount = fetchCount + 1;
			countCheck();
			assert (instrAdr == modelPc)
			else
			begin
				$display("ERROR t=%0t instrAdr got %h expected %h", $time, instrAdr, modelPc);
				countError();
			end
			// Model follows its own PC
			prevPc = modelPc;
			stepModel(imem[modelPc[7:2]]);
			if (modelPc == prevPc)
				runDone = 1'b1;
		end
		if (!reset && dataStb && dataAck && dataWe)
		begin
			storeCount = storeCount + 1;
			if (storeAddrQ.size() == 0)
			begin
				$display("store to %h at t=%0t has no matching store in the model",
					dataAdr, $time);
				countError();
			end
			else
			begin
				expAddr = storeAddrQ.pop_front();
				expData = storeDataQ.pop_front();
				countCheck();
				assert (dataAdr == expAddr)
				else
				begin
					$display("ERROR t=%0t dataAdr got %h expected %h", $time, dataAdr, expAddr);
					countError();
				end
				countCheck();
				assert (dataWrite == expData)
				else
				begin
					$display("ERROR t=%0t dataWrite got %h expected %h", $time, dataWrite,
						expData);
					countError();
				end
			end
		end
	end

	// Run limit from the worst case per instruction
	always @(posedge clk)
	begin
		cycleCount = cycleCount + 1;
		if (cycleCount > cycleLimit)
		begin
			$display("timeout after %0d cycles, the final jump was never reached", cycleLimit);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	initial
	begin
		instrDat = '0;
		instrAck = 1'b0;
		dataRead = '0;
		dataAck = 1'b0;
		instrWaiting = 1'b0;
		dataWaiting = 1'b0;
		instrDelay = 2'd0;
		dataDelay = 2'd0;
		lfsrState = 16'd96;
		stallCycles = 0;
		curTest = 0;
		checkCount = 0;
		errorCount = 0;
		fetchCount = 0;
		storeCount = 0;
		cycleCount = 0;
		runDone = 1'b0;
		modelPc = resetPc;
		testStart = '{32'd0, 32'd56, 32'd104, 32'd136, 32'd176};
		testName = '{"R-type", "immediates", "load store", "branches", "jumps"};
		for (int i = 0; i < 32; i++)
			modelRegs[i] = '0;
		for (int i = 0; i < 64; i++)
		begin
			imem[i] = '0;
			dmem[i] = fillWord(i);
			modelMem[i] = dmem[i];
		end
		loadProgram();

		wait (runDone);
		if (storeAddrQ.size() != 0)
		begin
			$display("%0d model stores never reached the data bus", storeAddrQ.size());
			countError();
		end
		reportTest(curTest);
		$display("test 6 random ack delays: %0d fetches, %0d stores, %0d stall cycles, %0d errors",
			fetchCount, storeCount, stallCycles, errorCount);
		$display("summary: %0d checks, %0d errors", checkCount, errorCount);
		if (errorCount == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

/* mipsCore.f */
src/mipsPkg.sv
src/ControlModule.sv
src/fetchUnit.sv
src/registerFile.sv
src/aluUnit.sv
src/memoryAccess.sv
src/mipsCore.sv
bench/clockGen.sv
bench/mipsCore_assertions.sv
bench/mipsCore_tb.sv

/* run.sh */
#!/bin/bash
# Build and run the mipsCore testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module mipsCore_tb -f mipsCore.f \
	--Mdir obj_dir -o simv

./obj_dir/simv 2>&1 | tee sim.log

if grep -q "STATUS: FAIL" sim.log; then
	echo "simulation reported failure"
	exit 1
fi
echo "simulation finished without failure"

/* src/ControlModule.sv */
module ControlModule
(
	input mipsPkg::opcode_t instr,
	output mipsPkg::aluOp_t aluOp,
	output logic isJump,
	output logic isNotConditional,
	output logic isEq,
	output logic memWrite,
	output logic memRead,
	output logic aluSrc,
	output logic regDst,
	output mipsPkg::wbi_t wbi
);
	import mipsPkg::*;

	// Jump and branch group, jal included
	logic isFlow;

	assign isFlow = (instr == opJ) || (instr == 6'd3) || (instr == opBeq) || (instr == opBne);

	////////////////////////////////////////////////////////////
	// ALU operation
	////////////////////////////////////////////////////////////

	always_comb
	begin
		// Loads and stores compute address
		if (instr[5])
			aluOp = aluAdd;
		// Branches compare by subtraction
		else if (isFlow)
			aluOp = aluSub;
		else if (instr == opRType)
			aluOp = aluFunct;
		// Immediates carry their own op
		else
			aluOp = instr[3:0];
	end

	////////////////////////////////////////////////////////////
	// Flow, memory and operand controls
	////////////////////////////////////////////////////////////

	assign isJump = isFlow;
	// Bit 2 set only for beq and bne
	assign isNotConditional = ~instr[2];
	assign isEq = ~instr[0];

	// Store and load groups
	assign memWrite = (instr[5:3] == 3'b101);
	assign memRead = (instr[5:3] == 3'b100);

	// Immediate operand for memory and immediate ALU ops
	assign aluSrc = instr[5] | instr[3];

	// Destination is rd
	assign regDst = (instr == opRType) || (instr == opBeq) || (instr == opBne)
		|| (instr == 6'd40) || (instr == 6'd41) || (instr == opSw);

	////////////////////////////////////////////////////////////
	// Writeback info
	////////////////////////////////////////////////////////////

	always_comb
	begin
		// Source select, memory for load group and lui
		if ((instr == 6'd32) || (instr == 6'd33) || (instr == opLw) || (instr == 6'd39)
			|| (instr == 6'd36) || (instr == 6'd37) || (instr == 6'd15))
			wbi[0] = 1'b0;
		else
			wbi[0] = 1'b1;

		// No register write for stores and flow
		if ((instr[5:3] == 3'b101) || isFlow)
			wbi[1] = 1'b0;
		else
			wbi[1] = 1'b1;
	end

endmodule

/* src/aluUnit.sv */
module aluUnit
(
	input mipsPkg::aluOp_t aluOp,
	input logic aluSrc,
	input logic [5:0] funct,
	input mipsPkg::word_t regA,
	input mipsPkg::word_t regB,
	input mipsPkg::word_t immediate,
	output mipsPkg::word_t result,
	output logic zero
);
	import mipsPkg::*;

	aluOp_t op;
	word_t extImm;
	word_t operandB;

	// R-type ops come from the function code
	always_comb
	begin
		op = aluOp;
		if (aluOp == aluFunct)
		begin
			case (funct)
				fnAdd: op = aluAdd;
				fnSub: op = aluSub;
				fnAnd: op = aluAnd;
				fnOr: op = aluOr;
				fnSlt: op = aluSlt;
				default: op = aluAdd;
			endcase
		end
	end

	// Logical immediates zero-extend, the rest sign-extend
	assign extImm = ((aluOp == aluAnd) || (aluOp == aluOr)) ?
		{16'h0000, immediate[15:0]} : {{16{immediate[15]}}, immediate[15:0]};
	assign operandB = aluSrc ? extImm : regB;

	always_comb
	begin
		case (op)
			aluAdd, opAddi[3:0]: result = regA + operandB;
			aluSub: result = regA - operandB;
			aluAnd: result = regA & operandB;
			aluOr: result = regA | operandB;
			// Signed compare
			aluSlt: result = ($signed(regA) < $signed(operandB)) ? 32'd1 : 32'd0;
			default: result = regA + operandB;
		endcase
	end

	assign zero = (result == 32'd0);

endmodule

/* src/fetchUnit.sv */
module fetchUnit
(
	input logic clk,
	input logic reset,
	output logic instrCyc,
	output logic instrStb,
	output mipsPkg::word_t instrAdr,
	input mipsPkg::word_t instrDat,
	input logic instrAck,
	input logic memDone,
	input logic needMemory,
	input logic branchTaken,
	input mipsPkg::word_t branchTarget,
	output mipsPkg::phase_t phase,
	output mipsPkg::word_t instruction,
	output mipsPkg::word_t pcPlus4
);
	import mipsPkg::*;

	word_t pc;

	// PC holds for the whole fetch
	assign instrAdr = pc;
	assign pcPlus4 = pc + 32'd4;

	// Latched instruction, valid from execute on
	always_ff @(posedge clk)
	begin
		if (phase == phFetch && instrStb && instrAck)
			instruction <= instrDat;
	end

	////////////////////////////////////////////////////////////
	// Phase FSM
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			pc <= resetPc;
			phase <= phFetch;
			instrCyc <= 1'b0;
			instrStb <= 1'b0;
		end
		else
		begin
			case (phase)
				phFetch:
				begin
					// Raise request, then wait for ack
					if (!instrStb)
					begin
						instrCyc <= 1'b1;
						instrStb <= 1'b1;
					end
					else if (instrAck)
					begin
						instrCyc <= 1'b0;
						instrStb <= 1'b0;
						phase <= phExecute;
					end
				end
				phExecute:
					phase <= needMemory ? phMemory : phWriteback;
				phMemory:
				begin
					if (memDone)
						phase <= phWriteback;
				end
				phWriteback:
				begin
					pc <= branchTaken ? branchTarget : pcPlus4;
					phase <= phFetch;
				end
				default:
					phase <= phFetch;
			endcase
		end
	end

endmodule

/* src/memoryAccess.sv */
module memoryAccess
(
	input logic clk,
	input logic reset,
	input mipsPkg::phase_t phase,
	input logic memRead,
	input logic memWrite,
	input mipsPkg::word_t address,
	input mipsPkg::word_t storeData,
	output logic dataCyc,
	output logic dataStb,
	output logic dataWe,
	output mipsPkg::word_t dataAdr,
	output mipsPkg::word_t dataWrite,
	input mipsPkg::word_t dataRead,
	input logic dataAck,
	output mipsPkg::word_t loadData,
	output logic memDone
);
	import mipsPkg::*;

	logic startXfer;

	// New request only on a memory op with no transfer open
	assign startXfer = (phase == phMemory) && (memRead || memWrite) && !dataStb;
	// Ack cycle ends the memory phase
	assign memDone = dataStb && dataAck;

	////////////////////////////////////////////////////////////
	// Bus control
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			dataCyc <= 1'b0;
			dataStb <= 1'b0;
			dataWe <= 1'b0;
		end
		else if (startXfer)
		begin
			dataCyc <= 1'b1;
			dataStb <= 1'b1;
			dataWe <= memWrite;
		end
		else if (memDone)
		begin
			dataCyc <= 1'b0;
			dataStb <= 1'b0;
			dataWe <= 1'b0;
		end
	end

	// Address and store data held until ack
	always_ff @(posedge clk)
	begin
		if (startXfer)
		begin
			dataAdr <= address;
			dataWrite <= storeData;
		end
	end

	// Load capture for writeback
	always_ff @(posedge clk)
	begin
		if (memDone && memRead)
			loadData <= dataRead;
	end

endmodule

/* src/mipsCore.sv */
module mipsCore
(
	input logic clk,
	input logic reset,
	output logic instrCyc,
	output logic instrStb,
	output mipsPkg::word_t instrAdr,
	input mipsPkg::word_t instrDat,
	input logic instrAck,
	output logic dataCyc,
	output logic dataStb,
	output logic dataWe,
	output mipsPkg::word_t dataAdr,
	output mipsPkg::word_t dataWrite,
	input mipsPkg::word_t dataRead,
	input logic dataAck
);
	import mipsPkg::*;

	phase_t phase;
	word_t instruction;
	word_t pcPlus4;
	word_t branchTarget;
	word_t readDataA;
	word_t readDataB;
	word_t aluResult;
	word_t loadData;
	word_t writeData;
	regAddr_t writeAddr;
	aluOp_t aluOp;
	wbi_t wbi;
	logic isJump;
	logic isNotConditional;
	logic isEq;
	logic memWrite;
	logic memRead;
	logic aluSrc;
	logic regDst;
	logic zero;
	logic memDone;
	logic needMemory;
	logic branchTaken;
	logic regWrite;

	////////////////////////////////////////////////////////////
	// Fetch and sequencing
	////////////////////////////////////////////////////////////

	fetchUnit fetch
	(
		.clk(clk),
		.reset(reset),
		.instrCyc(instrCyc),
		.instrStb(instrStb),
		.instrAdr(instrAdr),
		.instrDat(instrDat),
		.instrAck(instrAck),
		.memDone(memDone),
		.needMemory(needMemory),
		.branchTaken(branchTaken),
		.branchTarget(branchTarget),
		.phase(phase),
		.instruction(instruction),
		.pcPlus4(pcPlus4)
	);

	////////////////////////////////////////////////////////////
	// Decode, registers and ALU
	////////////////////////////////////////////////////////////

	ControlModule control
	(
		.instr(instruction[31:26]),
		.aluOp(aluOp),
		.isJump(isJump),
		.isNotConditional(isNotConditional),
		.isEq(isEq),
		.memWrite(memWrite),
		.memRead(memRead),
		.aluSrc(aluSrc),
		.regDst(regDst),
		.wbi(wbi)
	);

	// rd for R-type, rt otherwise
	assign writeAddr = regDst ? instruction[15:11] : instruction[20:16];
	// Write lands at the writeback edge
	assign regWrite = wbi[1] && (phase == phWriteback);
	assign writeData = wbi[0] ? aluResult : loadData;

	registerFile regs
	(
		.clk(clk),
		.reset(reset),
		.writeEnable(regWrite),
		.readAddrA(instruction[25:21]),
		.readAddrB(instruction[20:16]),
		.writeAddr(writeAddr),
		.writeData(writeData),
		.readDataA(readDataA),
		.readDataB(readDataB)
	);

	aluUnit alu
	(
		.aluOp(aluOp),
		.aluSrc(aluSrc),
		.funct(instruction[5:0]),
		.regA(readDataA),
		.regB(readDataB),
		.immediate(instruction),
		.result(aluResult),
		.zero(zero)
	);

	// j takes the absolute field, branches the scaled offset
	assign branchTarget = isNotConditional ?
		{pcPlus4[31:28], instruction[25:0], 2'b00} :
		pcPlus4 + {{14{instruction[15]}}, instruction[15:0], 2'b00};
	// beq on zero, bne on nonzero
	assign branchTaken = isJump && (isNotConditional || (zero ~^ isEq));

	////////////////////////////////////////////////////////////
	// Data memory
	////////////////////////////////////////////////////////////

	assign needMemory = memRead || memWrite;

	memoryAccess memAccess
	(
		.clk(clk),
		.reset(reset),
		.phase(phase),
		.memRead(memRead),
		.memWrite(memWrite),
		.address(aluResult),
		.storeData(readDataB),
		.dataCyc(dataCyc),
		.dataStb(dataStb),
		.dataWe(dataWe),
		.dataAdr(dataAdr),
		.dataWrite(dataWrite),
		.dataRead(dataRead),
		.dataAck(dataAck),
		.loadData(loadData),
		.memDone(memDone)
	);

endmodule

/* src/mipsPkg.sv */
package mipsPkg;

	////////////////////////////////////////////////////////////
	// Widths
	////////////////////////////////////////////////////////////

	// Data, instruction and address word
	typedef logic [31:0] word_t;
	typedef logic [4:0] regAddr_t;
	typedef logic [5:0] opcode_t;
	typedef logic [3:0] aluOp_t;
	// Bit 1 register write, bit 0 source with 1 for ALU and 0 for memory
	typedef logic [1:0] wbi_t;

	////////////////////////////////////////////////////////////
	// Opcodes
	////////////////////////////////////////////////////////////

	localparam opcode_t opRType = 6'd0;
	localparam opcode_t opJ = 6'd2;
	localparam opcode_t opBeq = 6'd4;
	localparam opcode_t opBne = 6'd5;
	localparam opcode_t opAddi = 6'd8;
	localparam opcode_t opSlti = 6'd10;
	localparam opcode_t opAndi = 6'd12;
	localparam opcode_t opOri = 6'd13;
	localparam opcode_t opLw = 6'd35;
	localparam opcode_t opSw = 6'd43;

	// ALU operations, immediate ones match low opcode bits
	localparam aluOp_t aluAdd = 4'd0;
	localparam aluOp_t aluSub = 4'd1;
	localparam aluOp_t aluFunct = 4'd2;
	localparam aluOp_t aluSlt = 4'd10;
	localparam aluOp_t aluAnd = 4'd12;
	localparam aluOp_t aluOr = 4'd13;

	// R-type function codes
	localparam logic [5:0] fnAdd = 6'd32;
	localparam logic [5:0] fnSub = 6'd34;
	localparam logic [5:0] fnAnd = 6'd36;
	localparam logic [5:0] fnOr = 6'd37;
	localparam logic [5:0] fnSlt = 6'd42;

	localparam word_t resetPc = 32'h0000_0000;

	// Instruction sequencing phases
	typedef enum logic [1:0] {phFetch, phExecute, phMemory, phWriteback} phase_t;

endpackage

/* src/registerFile.sv */
module registerFile
(
	input logic clk,
	input logic reset,
	input logic writeEnable,
	input mipsPkg::regAddr_t readAddrA,
	input mipsPkg::regAddr_t readAddrB,
	input mipsPkg::regAddr_t writeAddr,
	input mipsPkg::word_t writeData,
	output mipsPkg::word_t readDataA,
	output mipsPkg::word_t readDataB
);
	import mipsPkg::*;

	word_t regs [32];

	// Register 0 stays at its reset value
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end
		else if (writeEnable && (writeAddr != 5'd0))
			regs[writeAddr] <= writeData;
	end

	// Combinational read ports
	assign readDataA = regs[readAddrA];
	assign readDataB = regs[readAddrB];

endmodule
